// File: wb_host.f
+incdir+common
common/wbh_pkg.sv
rtl/wbh_reg.sv
rtl/wbh_remote_port.sv
rtl/wbh_req_stage.sv
rtl/wbh_top.sv
verif/wbh_tb.sv

// File: verif/wbh_tb.sv
// testbench for the host bridge, clock, reset, slave model, reference function, checks
`timescale 1ns/1ns
`include "wbh_config.svh"

module wbh_tb;

    localparam int N_ACC   = 45;                          // accesses in the sequence
    localparam int LIMIT   = 40 * N_ACC + 10;             // cycle budget incl. reset
    localparam int LOC_LAT = 2;                           // sampled on edge 1, ack on edge 2
    localparam wbh_pkg::addr_t ERR_ADR = 32'h1007_fff0;   // slave answers err here
    localparam wbh_pkg::addr_t LOC     = 32'h0008_0000;   // local window base

    typedef struct packed {
        wbh_pkg::data_t dat;    // read data
        wbh_pkg::addr_t adr;    // slave address
        logic           err;
        logic           rem;    // remote window
        logic           rd;
    } exp_t;

    typedef struct packed {
        wbh_pkg::data_t dat;
        wbh_pkg::addr_t adr;    // as seen by the slave model
        logic           ack;
        logic           err;
        logic [7:0]     lat;    // edges from strobe to response
    } act_t;

    logic           wbm_clk_i, s_reset_n, wbm_cyc_i, wbm_stb_i, wbm_we_i;
    wbh_pkg::addr_t wbm_adr_i, wbs_adr_o;
    wbh_pkg::data_t wbm_dat_i, wbm_dat_o, wbs_dat_o, wbs_dat_i;
    wbh_pkg::sel_t  wbm_sel_i, wbs_sel_o;
    logic           wbm_ack_o, wbm_err_o, wbs_cyc_o, wbs_stb_o, wbs_we_o, wbs_ack_i, wbs_err_i;
    wbh_pkg::data_t cfg_clk_skew_ctrl1_o, cfg_clk_skew_ctrl2_o;

    wbh_pkg::bank_t sh_bank;                    // shadow of the local regs
    wbh_pkg::data_t sh_skew1, sh_skew2;
    wbh_pkg::data_t exp_mem [wbh_pkg::addr_t];  // expected slave memory
    wbh_pkg::data_t slv_mem [wbh_pkg::addr_t];  // slave model storage
    wbh_pkg::addr_t slv_adr_q [$];
    exp_t           exp_q [$];
    act_t           act_q [$];
    string          name_q [$];
    int             errors;
    int             cycles;

    wbh_top dut_i (.*);

    // unwritten memory word, mixes every address bit
    function automatic wbh_pkg::data_t fill(input wbh_pkg::addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h3c5a_a5c3;
    endfunction

    function automatic wbh_pkg::data_t merge_bytes(input wbh_pkg::data_t old_v,
            input wbh_pkg::data_t new_v, input wbh_pkg::sel_t be);
        wbh_pkg::data_t r;
        r = old_v;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) r[8*i +: 8] = new_v[8*i +: 8];
        end
        return r;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic exp_t exp_rsp(input wbh_pkg::addr_t adr, input logic we,
            input wbh_pkg::data_t dat, input wbh_pkg::sel_t sel);
        exp_t           e;
        wbh_pkg::data_t new_v;
        e     = '0;
        e.rem = ~adr[`WBH_WIN_BIT];
        e.rd  = ~we;
        if (!e.rem) begin
            case (adr[4:2])
                `WBH_REG_BANK:  e.dat = {16'h0000, sh_bank};
                `WBH_REG_SKEW1: e.dat = sh_skew1;
                `WBH_REG_SKEW2: e.dat = sh_skew2;
                `WBH_REG_ID:    e.dat = `WBH_ID_VAL;
                default:        e.dat = '0;       // unmapped
            endcase
            new_v = merge_bytes(e.dat, dat, sel);
            if (we && adr[4:2] == `WBH_REG_BANK)  sh_bank  = new_v[15:0];
            if (we && adr[4:2] == `WBH_REG_SKEW1) sh_skew1 = new_v;
            if (we && adr[4:2] == `WBH_REG_SKEW2) sh_skew2 = new_v;
        end else begin
            e.adr = {sh_bank[15:3], adr[18:0]};   // bank rule
            e.err = (e.adr == ERR_ADR);
            e.dat = exp_mem.exists(e.adr) ? exp_mem[e.adr] : fill(e.adr);
            if (we && !e.err) exp_mem[e.adr] = merge_bytes(e.dat, dat, sel);
        end
        return e;
    endfunction

    task automatic check_data(input string name, input wbh_pkg::data_t exp,
            input wbh_pkg::data_t act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input wbh_pkg::addr_t exp,
            input wbh_pkg::addr_t act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // one classic cycle, held until ack or err
    task automatic bus_access(input string name, input wbh_pkg::addr_t adr, input logic we,
            input wbh_pkg::data_t dat, input wbh_pkg::sel_t sel);
        act_t a;
        int   n;
        a = '0;
        n = 0;
        exp_q.push_back(exp_rsp(adr, we, dat, sel));
        name_q.push_back(name);
        wbm_adr_i = adr;
        wbm_we_i  = we;
        wbm_dat_i = dat;
        wbm_sel_i = sel;
        wbm_cyc_i = 1'b1;
        wbm_stb_i = 1'b1;
        do begin
            @(posedge wbm_clk_i);
            #1;
            n++;
        end while (!(wbm_ack_o || wbm_err_o) && n < 40);
        if (!(wbm_ack_o || wbm_err_o)) begin
            errors++;
            $display("%s: no ack or err from the bridge within 40 cycles", name);
        end
        a.ack = wbm_ack_o;
        a.err = wbm_err_o;
        a.dat = wbm_dat_o;
        a.lat = n[7:0];
        a.adr = (slv_adr_q.size() != 0) ? slv_adr_q.pop_front() : '0;
        wbm_cyc_i = 1'b0;                 // stb low for at least one edge
        wbm_stb_i = 1'b0;
        @(posedge wbm_clk_i);
        #1;
        if (wbm_ack_o || wbm_err_o || slv_adr_q.size() != 0) begin
            errors++;
            $display("%s: bridge answered the same access more than once", name);
        end
        act_q.push_back(a);
    endtask

    initial begin : clock_gen
        wbm_clk_i = 1'b0;
        forever #2 wbm_clk_i = ~wbm_clk_i;
    end

    always @(posedge wbm_clk_i) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("run stopped after %0d cycles, accesses never finished, %0d errors",
                     cycles, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // slave model, random wait states
    // ------------------------------
    initial begin : slave_model
        int unsigned    wait_n;
        wbh_pkg::data_t old_v;
        wbs_ack_i = 1'b0;
        wbs_err_i = 1'b0;
        wbs_dat_i = '0;
        wait_n    = $urandom(32'h716f260b);   // the only seed of the run
        forever begin
            @(posedge wbm_clk_i);
            #1;
            if (wbs_cyc_o && wbs_stb_o) begin
                slv_adr_q.push_back(wbs_adr_o);
                wait_n = $urandom_range(3, 0);
                repeat (wait_n) begin
                    @(posedge wbm_clk_i);
                    #1;
                end
                old_v = slv_mem.exists(wbs_adr_o) ? slv_mem[wbs_adr_o] : fill(wbs_adr_o);
                if (wbs_adr_o == ERR_ADR) begin
                    wbs_err_i = 1'b1;
                end else begin
                    wbs_ack_i = 1'b1;
                    wbs_dat_i = old_v;        // writes return the old word
                    if (wbs_we_o) slv_mem[wbs_adr_o] = merge_bytes(old_v, wbs_dat_o, wbs_sel_o);
                end
                @(posedge wbm_clk_i);
                #1;
                wbs_ack_i = 1'b0;
                wbs_err_i = 1'b0;
            end
        end
    end

    // compare expected against actual, one entry per access
    initial begin : compare
        exp_t  e;
        act_t  a;
        string nm;
        forever begin
            @(posedge wbm_clk_i);
            while (act_q.size() != 0) begin
                e  = exp_q.pop_front();
                a  = act_q.pop_front();
                nm = name_q.pop_front();
                check_flag({nm, " err"}, e.err, a.err);
                check_flag({nm, " ack"}, ~e.err, a.ack);
                if (e.rd && !e.err) check_data({nm, " data"}, e.dat, a.dat);
                if (e.rem) check_addr({nm, " slave adr"}, e.adr, a.adr);
                else check_count({nm, " latency"}, LOC_LAT, int'(a.lat));
            end
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin : test_seq
        wbh_pkg::bank_t banks [4] = '{16'h2a48, 16'hffff, 16'h0008, 16'h7777};
        wbh_pkg::addr_t ra;
        wbm_cyc_i = 1'b0;
        wbm_stb_i = 1'b0;
        wbm_we_i  = 1'b0;
        wbm_adr_i = '0;
        wbm_dat_i = '0;
        wbm_sel_i = '0;
        sh_bank   = `WBH_BANK_RST;
        sh_skew1  = `WBH_SKEW_RST;
        sh_skew2  = `WBH_SKEW_RST;
        s_reset_n = 1'b0;
        repeat (10) @(posedge wbm_clk_i);
        #1;
        s_reset_n = 1'b1;
        check_data("dat after reset", '0, wbm_dat_o);
        check_flag("ack after reset", 1'b0, wbm_ack_o);
        check_flag("err after reset", 1'b0, wbm_err_o);
        check_flag("slave cyc after reset", 1'b0, wbs_cyc_o);
        check_flag("slave stb after reset", 1'b0, wbs_stb_o);
        for (int i = 0; i < 4; i++) begin
            bus_access($sformatf("reset rd idx %0d", i), LOC + 4 * i, 1'b0, '0, 4'h0);
        end
        // byte enables on the skew words
        bus_access("wr skew1 full", LOC + 4, 1'b1, 32'hdead_beef, 4'b1111);
        bus_access("wr skew1 part", LOC + 4, 1'b1, 32'h1234_5678, 4'b0101);
        bus_access("rd skew1", LOC + 4, 1'b0, '0, 4'h0);
        bus_access("wr skew2 part", LOC + 8, 1'b1, 32'hcafe_f00d, 4'b1010);
        bus_access("rd skew2", LOC + 8, 1'b0, '0, 4'h0);
        check_data("cfg skew1 out", sh_skew1, cfg_clk_skew_ctrl1_o);
        check_data("cfg skew2 out", sh_skew2, cfg_clk_skew_ctrl2_o);
        bus_access("wr id", LOC + 12, 1'b1, 32'h0bad_0bad, 4'b1111);   // read only
        bus_access("rd id", LOC + 12, 1'b0, '0, 4'h0);
        bus_access("wr unmapped", LOC + 24, 1'b1, 32'hffff_ffff, 4'b1111);
        bus_access("rd unmapped 6", LOC + 24, 1'b0, '0, 4'h0);
        bus_access("rd unmapped 5", LOC + 20, 1'b0, '0, 4'h0);
        // remote window under several banks, upper master bits dropped
        for (int i = 0; i < 4; i++) begin
            ra = 32'h7ff3_2340 + 8 * i;
            bus_access($sformatf("wr bank %0d", i), LOC, 1'b1, {16'h5555, banks[i]}, 4'b0011);
            // fewer byte lanes each round
            bus_access($sformatf("rem wr %0d", i), ra, 1'b1, 32'ha5a5_0000 + i, 4'hf >> i);
            bus_access($sformatf("rem rd %0d", i), ra, 1'b0, '0, 4'h0);
            bus_access($sformatf("rem rd fill %0d", i), ra + 4, 1'b0, '0, 4'h0);
        end
        bus_access("wr bank back", LOC, 1'b1, 32'h0000_1000, 4'b0011);
        bus_access("rem err", 32'h0007_fff0, 1'b0, '0, 4'h0);
        bus_access("rem rd after err", 32'h0007_ffe0, 1'b0, '0, 4'h0);
        // back to back, slave wait states vary
        for (int i = 0; i < 12; i++) begin
            bus_access($sformatf("b2b %0d", i), 32'h0000_0100 + 4 * (i % 4), i < 4,
                       32'h9e37_79b9 * (i + 1), 4'b1111);
        end
        repeat (2) @(posedge wbm_clk_i);
        $display("checks done, %0d errors", errors);
        if (errors == 0) $display("TESTS PASSED");
        else $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: rtl/wbh_top.sv
// wishbone host bridge top, master port, request stage, local regs, remote port
`timescale 1ns/1ns

module wbh_top (
    input  logic            wbm_clk_i,              // system clock
    input  logic            s_reset_n,              // sync reset, active low

    // master port
    input  logic            wbm_cyc_i,              // cycle
    input  logic            wbm_stb_i,              // strobe/request
    input  wbh_pkg::addr_t  wbm_adr_i,              // address
    input  logic            wbm_we_i,               // write
    input  wbh_pkg::data_t  wbm_dat_i,              // write data
    input  wbh_pkg::sel_t   wbm_sel_i,              // byte enable
    output wbh_pkg::data_t  wbm_dat_o,              // read data
    output logic            wbm_ack_o,              // acknowledge
    output logic            wbm_err_o,              // error

    // slave port
    output logic            wbs_cyc_o,
    output logic            wbs_stb_o,
    output wbh_pkg::addr_t  wbs_adr_o,              // banked address
    output logic            wbs_we_o,
    output wbh_pkg::data_t  wbs_dat_o,
    output wbh_pkg::sel_t   wbs_sel_o,
    input  wbh_pkg::data_t  wbs_dat_i,
    input  logic            wbs_ack_i,
    input  logic            wbs_err_i,

    // clock skew words
    output wbh_pkg::data_t  cfg_clk_skew_ctrl1_o,
    output wbh_pkg::data_t  cfg_clk_skew_ctrl2_o
);

    // ------------------------------
    // internal wires
    // ------------------------------
    logic           loc_stb;     // local window strobe
    logic           rem_stb;     // remote window strobe
    wbh_pkg::req_t  int_req;     // registered request, shared by both targets
    wbh_pkg::rsp_t  loc_rsp;
    wbh_pkg::rsp_t  rem_rsp;
    wbh_pkg::bank_t bank_sel;    // upper slave address bits

    // flat master port packed in struct field order
    wbh_req_stage u_req_stage (
        .wbm_clk_i  (wbm_clk_i),
        .s_reset_n  (s_reset_n),
        .wbm_cyc_i  (wbm_cyc_i),
        .wbm_stb_i  (wbm_stb_i),
        .wbm_req_i  ({wbm_adr_i, wbm_we_i, wbm_dat_i, wbm_sel_i}),
        .loc_rsp_i  (loc_rsp),
        .rem_rsp_i  (rem_rsp),
        .loc_stb_o  (loc_stb),
        .rem_stb_o  (rem_stb),
        .req_o      (int_req),
        .wbm_dat_o  (wbm_dat_o),
        .wbm_ack_o  (wbm_ack_o),
        .wbm_err_o  (wbm_err_o)
    );

    wbh_reg u_reg (
        .wbm_clk_i              (wbm_clk_i),
        .s_reset_n              (s_reset_n),
        .loc_stb_i              (loc_stb),
        .loc_req_i              (int_req),
        .loc_rsp_o              (loc_rsp),
        .bank_sel_o             (bank_sel),
        .cfg_clk_skew_ctrl1_o   (cfg_clk_skew_ctrl1_o),
        .cfg_clk_skew_ctrl2_o   (cfg_clk_skew_ctrl2_o)
    );

    wbh_remote_port u_remote (
        .wbm_clk_i  (wbm_clk_i),
        .s_reset_n  (s_reset_n),
        .rem_stb_i  (rem_stb),
        .rem_req_i  (int_req),
        .bank_sel_i (bank_sel),
        .wbs_dat_i  (wbs_dat_i),
        .wbs_ack_i  (wbs_ack_i),
        .wbs_err_i  (wbs_err_i),
        .rem_rsp_o  (rem_rsp),
        .wbs_cyc_o  (wbs_cyc_o),
        .wbs_stb_o  (wbs_stb_o),
        .wbs_adr_o  (wbs_adr_o),
        .wbs_we_o   (wbs_we_o),
        .wbs_dat_o  (wbs_dat_o),
        .wbs_sel_o  (wbs_sel_o)
    );

endmodule

// File: rtl/wbh_req_stage.sv
// request register, window decode, response mux and registered master response
`timescale 1ns/1ns
`include "wbh_config.svh"

module wbh_req_stage (
    input  logic            wbm_clk_i,
    input  logic            s_reset_n,
    input  logic            wbm_cyc_i,
    input  logic            wbm_stb_i,
    input  wbh_pkg::req_t   wbm_req_i,      // master request, flat port packed
    input  wbh_pkg::rsp_t   loc_rsp_i,      // from local regs
    input  wbh_pkg::rsp_t   rem_rsp_i,      // from remote port
    output logic            loc_stb_o,
    output logic            rem_stb_o,
    output wbh_pkg::req_t   req_o,          // registered request
    output wbh_pkg::data_t  wbm_dat_o,
    output logic            wbm_ack_o,
    output logic            wbm_err_o
);

    logic           qual_stb;   // stb qualified with cyc
    logic           stb_q;      // one cycle internal request
    logic           busy_q;     // access in flight
    logic           pending;    // blocks a repeat strobe
    logic           loc_win;    // local window hit
    wbh_pkg::req_t  req_q;
    wbh_pkg::rsp_t  sel_rsp;    // muxed target response

    assign qual_stb = wbm_cyc_i & wbm_stb_i;

    // no new request while one is issued, in flight, arriving or registered
    assign pending  = stb_q | busy_q | sel_rsp.ack | sel_rsp.err | wbm_ack_o | wbm_err_o;

    // ------------------------------
    // request register
    // ------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            stb_q  <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            stb_q <= qual_stb & ~pending;
            if (stb_q) begin
                busy_q <= 1'b1;            // issued, wait for response
            end else if (wbm_ack_o | wbm_err_o) begin
                busy_q <= 1'b0;            // response has left the bridge
            end
        end
    end

    // payload captured with the strobe and held for the whole access
    always_ff @(posedge wbm_clk_i) begin
        if (qual_stb && !pending) begin
            req_q <= wbm_req_i;
        end
    end

    assign req_o = req_q;

    // ------------------------------
    // window decode
    // ------------------------------
    assign loc_win   = req_q.adr[`WBH_WIN_BIT];
    assign loc_stb_o = stb_q & loc_win;
    assign rem_stb_o = stb_q & ~loc_win;

    // select stays valid while busy, req_q is frozen
    assign sel_rsp = loc_win ? loc_rsp_i : rem_rsp_i;

    // ------------------------------
    // registered response
    // ------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            wbm_ack_o <= 1'b0;
            wbm_err_o <= 1'b0;
            wbm_dat_o <= '0;
        end else begin
            wbm_ack_o <= sel_rsp.ack;
            wbm_err_o <= sel_rsp.err;
            if (sel_rsp.ack) begin
                wbm_dat_o <= sel_rsp.dat;  // last read data stays on the bus
            end
        end
    end

endmodule

// File: rtl/wbh_remote_port.sv
// bank address translation and wishbone classic slave cycle
`timescale 1ns/1ns
`include "wbh_config.svh"

module wbh_remote_port (
    input  logic            wbm_clk_i,
    input  logic            s_reset_n,
    input  logic            rem_stb_i,      // one cycle request strobe
    input  wbh_pkg::req_t   rem_req_i,
    input  wbh_pkg::bank_t  bank_sel_i,
    input  wbh_pkg::data_t  wbs_dat_i,
    input  logic            wbs_ack_i,
    input  logic            wbs_err_i,
    output wbh_pkg::rsp_t   rem_rsp_o,
    output logic            wbs_cyc_o,
    output logic            wbs_stb_o,
    output wbh_pkg::addr_t  wbs_adr_o,
    output logic            wbs_we_o,
    output wbh_pkg::data_t  wbs_dat_o,
    output wbh_pkg::sel_t   wbs_sel_o
);

    wbh_pkg::addr_t bank_adr;   // translated slave address
    logic           done;       // slave ends the cycle

    // indirect map {bank[15:3], adr[18:0]}
    assign bank_adr = {bank_sel_i[15:`WBH_BANK_LSB], rem_req_i.adr[`WBH_WIN_BIT-1:0]};
    assign done     = wbs_cyc_o & (wbs_ack_i | wbs_err_i);

    // ------------------------------
    // slave cycle control
    // ------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            wbs_cyc_o <= 1'b0;
            wbs_stb_o <= 1'b0;
        end else if (rem_stb_i) begin
            wbs_cyc_o <= 1'b1;
            wbs_stb_o <= 1'b1;
        end else if (done) begin
            wbs_cyc_o <= 1'b0;      // held until ack or err
            wbs_stb_o <= 1'b0;
        end
    end

    // slave payload, loaded with the strobe
    always_ff @(posedge wbm_clk_i) begin
        if (rem_stb_i) begin
            wbs_adr_o <= bank_adr;
            wbs_we_o  <= rem_req_i.we;
            wbs_dat_o <= rem_req_i.dat;
            wbs_sel_o <= rem_req_i.sel;
        end
    end

    // response for the single cycle the slave ends the access
    assign rem_rsp_o.dat = wbs_dat_i;
    assign rem_rsp_o.ack = wbs_cyc_o & wbs_ack_i;
    assign rem_rsp_o.err = wbs_cyc_o & wbs_err_i & ~wbs_ack_i;

endmodule

// File: rtl/wbh_reg.sv
// local configuration registers, bank select and skew words, byte writes and readback
`timescale 1ns/1ns
`include "wbh_config.svh"

module wbh_reg (
    input  logic            wbm_clk_i,
    input  logic            s_reset_n,
    input  logic            loc_stb_i,              // one cycle access strobe
    input  wbh_pkg::req_t   loc_req_i,
    output wbh_pkg::rsp_t   loc_rsp_o,
    output wbh_pkg::bank_t  bank_sel_o,
    output wbh_pkg::data_t  cfg_clk_skew_ctrl1_o,
    output wbh_pkg::data_t  cfg_clk_skew_ctrl2_o
);

    logic [2:0]     reg_idx;    // word index
    logic           reg_wr;
    wbh_pkg::bank_t bank_q;
    wbh_pkg::data_t skew1_q;
    wbh_pkg::data_t skew2_q;
    wbh_pkg::data_t rdata;
    wbh_pkg::data_t bank_wide;  // bank select widened to a bus word
    wbh_pkg::data_t bank_next;  // bank word after the byte merge

    // byte lane merge under the enables
    function automatic wbh_pkg::data_t be_merge(
        input wbh_pkg::data_t old_val,
        input wbh_pkg::data_t new_val,
        input wbh_pkg::sel_t  be
    );
        wbh_pkg::data_t res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) res[i*8 +: 8] = new_val[i*8 +: 8];
        end
        return res;
    endfunction

    assign reg_idx   = loc_req_i.adr[4:2];
    assign reg_wr    = loc_stb_i & loc_req_i.we;
    assign bank_wide = {16'h0000, bank_q};
    assign bank_next = be_merge(bank_wide, loc_req_i.dat, loc_req_i.sel);

    // ------------------------------
    // register writes
    // ------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            bank_q  <= `WBH_BANK_RST;
            skew1_q <= `WBH_SKEW_RST;
            skew2_q <= `WBH_SKEW_RST;
        end else if (reg_wr) begin
            case (reg_idx)
                `WBH_REG_BANK:  bank_q  <= bank_next[15:0];   // upper lanes have no storage
                `WBH_REG_SKEW1: skew1_q <= be_merge(skew1_q, loc_req_i.dat, loc_req_i.sel);
                `WBH_REG_SKEW2: skew2_q <= be_merge(skew2_q, loc_req_i.dat, loc_req_i.sel);
                default: ;      // id and unmapped, writes dropped
            endcase
        end
    end

    // ------------------------------
    // readback
    // ------------------------------
    always_comb begin
        case (reg_idx)
            `WBH_REG_BANK:  rdata = bank_wide;
            `WBH_REG_SKEW1: rdata = skew1_q;
            `WBH_REG_SKEW2: rdata = skew2_q;
            `WBH_REG_ID:    rdata = `WBH_ID_VAL;
            default:        rdata = '0;     // unmapped reads zero
        endcase
    end

    // single cycle access, ack with the strobe
    assign loc_rsp_o.dat = rdata;
    assign loc_rsp_o.ack = loc_stb_i;
    assign loc_rsp_o.err = 1'b0;        // local window never fails

    assign bank_sel_o           = bank_q;
    assign cfg_clk_skew_ctrl1_o = skew1_q;
    assign cfg_clk_skew_ctrl2_o = skew2_q;

endmodule

// File: common/wbh_pkg.sv
// data, address, byte enable and bank types, request and response structs

package wbh_pkg;

    // ------------------------------
    // basic bus types
    // ------------------------------
    typedef logic [31:0] data_t;   // bus data word
    typedef logic [31:0] addr_t;   // byte address
    typedef logic [3:0]  sel_t;    // one enable per byte lane
    typedef logic [15:0] bank_t;   // bank select register

    // ------------------------------
    // request, master to target
    // ------------------------------
    // field order follows the flat master port
    // adr, we, dat, sel -> 69 bits
    typedef struct packed {
        addr_t adr;    // byte address
        logic  we;     // 1 write, 0 read
        data_t dat;    // write data
        sel_t  sel;    // byte enables
    } req_t;

    // ------------------------------
    // response, target to master
    // ------------------------------
    // dat, ack, err -> 34 bits
    // a target raises ack or err for a single cycle
    typedef struct packed {
        data_t dat;    // read data, valid with ack
        logic  ack;    // access done
        logic  err;    // access failed
    } rsp_t;

    // idle response, handy for targets that are not selected
    localparam rsp_t RSP_IDLE = '{
        dat: '0,
        ack: 1'b0,
        err: 1'b0
    };

endpackage

// File: common/wbh_config.svh
// window bit, register indices, reset values and id word of the wishbone host bridge
`ifndef WBH_CONFIG_SVH
`define WBH_CONFIG_SVH

// ------------------------------
// address map
// ------------------------------
// bit 19 set   -> local register window
// bit 19 clear -> remote window, banked
`define WBH_WIN_BIT     19

// lowest bank bit that reaches the slave address
// slave address is {bank[15:3], adr[18:0]}
`define WBH_BANK_LSB    3

// ------------------------------
// register indices, adr[4:2]
// ------------------------------
`define WBH_REG_BANK    3'd0    // bank select
`define WBH_REG_SKEW1   3'd1    // clock skew control 1
`define WBH_REG_SKEW2   3'd2    // clock skew control 2
`define WBH_REG_ID      3'd3    // read only id

// ------------------------------
// reset values
// ------------------------------
`define WBH_BANK_RST    16'h1000
`define WBH_SKEW_RST    32'h0000_0000
`define WBH_ID_VAL      32'h5742_0001

`endif
